// ==== design/phold_pkg.sv ====
`default_nettype none

package phold_pkg;

   // core side
   localparam int NUM_CORE = 4;
   localparam int NB_COREID = 2;

   // logical processes
   localparam int NUM_LP = 16;
   localparam int NB_LPID = 4;

   // timestamps
   localparam int TIME_WID = 16;

   // event queue, count needs one bit more than the index
   localparam int QUEUE_DEPTH = 16;
   localparam int NB_QCNT = 5;

   typedef logic [NB_LPID-1:0] lp_id_t;

   typedef logic [TIME_WID-1:0] sim_time_t;

   // one bit per core
   typedef logic [NUM_CORE-1:0] core_vec_t;

   // run control
   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      INIT    = 2'd1,
      RUNNING = 2'd2,
      DONE    = 2'd3
   } sched_state_e;

endpackage

`default_nettype wire

// ==== design/event_if.sv ====
`default_nettype none

// one event in flight, vld/rdy handshake
interface event_if;

   logic                 vld;
   logic                 rdy;
   phold_pkg::lp_id_t    lp;
   phold_pkg::sim_time_t ts;
   // queue holds at least one entry
   logic                 pending;

   modport src (
      output vld,
      output lp,
      output ts,
      output pending,
      input  rdy
   );

   modport dst (
      input  vld,
      input  lp,
      input  ts,
      input  pending,
      output rdy
   );

endinterface

`default_nettype wire

// ==== design/rr_arbiter.sv ====
`default_nettype none

module rr_arbiter (
   input  logic                               clk,
   input  logic                               rst_n,
   input  phold_pkg::core_vec_t               req,
   input  logic                               adv,
   output phold_pkg::core_vec_t               gnt,
   output logic                               gnt_vld,
   output logic [phold_pkg::NB_COREID-1:0]    gnt_idx
);

   logic [phold_pkg::NB_COREID-1:0] ptr;
   logic [phold_pkg::NB_COREID-1:0] idx;

   // scan downward so the requester closest to ptr wins
   always_comb begin
      gnt_idx = '0;
      gnt_vld = 1'b0;
      idx = '0;
      for (int i = phold_pkg::NUM_CORE - 1; i >= 0; i--) begin
         idx = ptr + phold_pkg::NB_COREID'(i);
         if (req[idx]) begin
            gnt_idx = idx;
            gnt_vld = 1'b1;
         end
      end
      gnt = '0;
      if (gnt_vld) begin
         gnt[gnt_idx] = 1'b1;
      end
   end

   // next search starts just past the winner
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (adv && gnt_vld) begin
         ptr <= gnt_idx + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== design/event_collector.sv ====
`default_nettype none

module event_collector (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             init_en,
   input  logic [phold_pkg::NB_LPID:0]      num_init_events,
   output logic                             init_done,
   input  phold_pkg::core_vec_t             core_ev_vld,
   input  phold_pkg::core_vec_t             core_ev_null,
   input  phold_pkg::lp_id_t                core_ev_lp [phold_pkg::NUM_CORE],
   input  phold_pkg::sim_time_t             core_ev_ts [phold_pkg::NUM_CORE],
   output phold_pkg::core_vec_t             core_ev_ack,
   event_if.src                             ev_in
);

   logic [phold_pkg::NB_LPID:0]     init_cnt;
   logic [phold_pkg::NB_LPID:0]     init_lim;
   logic                            hold_vld;
   logic [phold_pkg::NB_COREID-1:0] hold_idx;
   phold_pkg::core_vec_t            rx_req;
   phold_pkg::core_vec_t            rx_gnt;
   logic                            rx_gnt_vld;
   logic [phold_pkg::NB_COREID-1:0] rx_idx;
   logic                            sel_null;
   logic                            take;

   // never more initial events than LPs
   assign init_lim = (num_init_events > (phold_pkg::NB_LPID + 1)'(phold_pkg::NUM_LP)) ?
                     (phold_pkg::NB_LPID + 1)'(phold_pkg::NUM_LP) : num_init_events;
   assign init_done = init_en && (init_cnt == init_lim);

   // a stalled offer keeps its grant until the queue takes it
   assign rx_req = hold_vld ? (core_ev_vld & (phold_pkg::core_vec_t'(1) << hold_idx)) :
                   core_ev_vld;
   assign sel_null = core_ev_null[rx_idx];

   always_comb begin
      if (init_en) begin
         ev_in.vld = (init_cnt < init_lim);
         ev_in.lp  = init_cnt[phold_pkg::NB_LPID-1:0];
         ev_in.ts  = '0;
      end else begin
         ev_in.vld = rx_gnt_vld && !sel_null;
         ev_in.lp  = core_ev_lp[rx_idx];
         ev_in.ts  = core_ev_ts[rx_idx];
      end
   end

   // null events are retired without touching the queue
   assign take = !init_en && rx_gnt_vld && (sel_null || ev_in.rdy);
   assign core_ev_ack = take ? rx_gnt : '0;

   rr_arbiter u_rx_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (rx_req),
      .adv     (take),
      .gnt     (rx_gnt),
      .gnt_vld (rx_gnt_vld),
      .gnt_idx (rx_idx)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         init_cnt <= '0;
         hold_vld <= 1'b0;
         hold_idx <= '0;
      end else begin
         if (init_en && ev_in.vld && ev_in.rdy) begin
            init_cnt <= init_cnt + 1'b1;
         end
         hold_vld <= !init_en && ev_in.vld && !ev_in.rdy;
         hold_idx <= rx_idx;
      end
   end

endmodule

`default_nettype wire

// ==== design/event_queue.sv ====
`default_nettype none

module event_queue (
   input  logic clk,
   input  logic rst_n,
   event_if.dst ev_in,
   event_if.src ev_out
);

   phold_pkg::sim_time_t           q_ts [phold_pkg::QUEUE_DEPTH];
   phold_pkg::lp_id_t              q_lp [phold_pkg::QUEUE_DEPTH];
   logic [phold_pkg::NB_QCNT-1:0]  cnt;
   logic [phold_pkg::NB_QCNT-1:0]  ins_pos;
   logic                           busy;
   logic                           full;
   logic                           empty;
   logic                           enq;
   logic                           deq;

   assign full  = (cnt == phold_pkg::NB_QCNT'(phold_pkg::QUEUE_DEPTH));
   assign empty = (cnt == '0);

   // one idle cycle after each operation, enqueue wins
   assign ev_in.rdy  = !full && !busy;
   assign ev_out.vld = !empty && !busy && !ev_in.vld;

   // head is always entry 0
   assign ev_out.lp      = q_lp[0];
   assign ev_out.ts      = q_ts[0];
   assign ev_out.pending = !empty;

   assign enq = ev_in.vld && ev_in.rdy;
   assign deq = ev_out.vld && ev_out.rdy;

   // first entry strictly later than the new one
   // equal stamps stay in arrival order
   always_comb begin
      ins_pos = cnt;
      for (int i = phold_pkg::QUEUE_DEPTH - 1; i >= 0; i--) begin
         if ((phold_pkg::NB_QCNT'(i) < cnt) && (q_ts[i] > ev_in.ts)) begin
            ins_pos = phold_pkg::NB_QCNT'(i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (enq) begin
         for (int i = phold_pkg::QUEUE_DEPTH - 1; i > 0; i--) begin
            if (phold_pkg::NB_QCNT'(i) > ins_pos) begin
               q_ts[i] <= q_ts[i-1];
               q_lp[i] <= q_lp[i-1];
            end
         end
         q_ts[ins_pos[phold_pkg::NB_QCNT-2:0]] <= ev_in.ts;
         q_lp[ins_pos[phold_pkg::NB_QCNT-2:0]] <= ev_in.lp;
      end else if (deq) begin
         for (int i = 0; i < phold_pkg::QUEUE_DEPTH - 1; i++) begin
            q_ts[i] <= q_ts[i+1];
            q_lp[i] <= q_lp[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt  <= '0;
         busy <= 1'b0;
      end else begin
         busy <= enq || deq;
         if (enq) begin
            cnt <= cnt + 1'b1;
         end else if (deq) begin
            cnt <= cnt - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/dispatch_unit.sv ====
`default_nettype none

module dispatch_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  run,
   input  phold_pkg::core_vec_t  core_rdy,
   input  phold_pkg::core_vec_t  core_done,
   event_if.dst                  ev_out,
   output phold_pkg::core_vec_t  disp_vld,
   output phold_pkg::lp_id_t     disp_lp,
   output phold_pkg::sim_time_t  disp_ts,
   output phold_pkg::sim_time_t  gvt
);

   phold_pkg::core_vec_t            tx_req;
   phold_pkg::core_vec_t            tx_gnt;
   logic                            tx_gnt_vld;
   logic [phold_pkg::NB_COREID-1:0] tx_idx;
   logic                            xfer;
   phold_pkg::core_vec_t            core_busy;
   phold_pkg::sim_time_t            busy_ts [phold_pkg::NUM_CORE];
   phold_pkg::sim_time_t            min_ts;
   logic                            min_vld;

   // only idle cores compete, and only while running
   assign tx_req = run ? core_rdy : '0;

   rr_arbiter u_tx_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (tx_req),
      .adv     (xfer),
      .gnt     (tx_gnt),
      .gnt_vld (tx_gnt_vld),
      .gnt_idx (tx_idx)
   );

   assign ev_out.rdy = tx_gnt_vld;
   assign xfer       = ev_out.vld && ev_out.rdy;
   assign disp_vld   = xfer ? tx_gnt : '0;

   // payload is broadcast, disp_vld picks the core
   assign disp_lp = ev_out.lp;
   assign disp_ts = ev_out.ts;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         core_busy <= '0;
      end else begin
         core_busy <= (core_busy & ~core_done) | disp_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (xfer) begin
         busy_ts[tx_idx] <= ev_out.ts;
      end
   end

   // earliest of queue head and events still executing
   always_comb begin
      min_vld = ev_out.pending;
      min_ts  = ev_out.ts;
      for (int i = 0; i < phold_pkg::NUM_CORE; i++) begin
         if (core_busy[i] && (!min_vld || (busy_ts[i] < min_ts))) begin
            min_vld = 1'b1;
            min_ts  = busy_ts[i];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (run && min_vld) begin
         gvt <= min_ts;
      end
   end

endmodule

`default_nettype wire

// ==== design/phold_sched.sv ====
`default_nettype none

module phold_sched (
   input  logic                         clk,
   input  logic                         rst_n,
   input  phold_pkg::sim_time_t         sim_end,
   input  logic [phold_pkg::NB_LPID:0]  num_init_events,
   output phold_pkg::sim_time_t         gvt,
   output logic                         rtn_vld,
   input  phold_pkg::core_vec_t         core_ev_vld,
   input  phold_pkg::core_vec_t         core_ev_null,
   input  phold_pkg::lp_id_t            core_ev_lp [phold_pkg::NUM_CORE],
   input  phold_pkg::sim_time_t         core_ev_ts [phold_pkg::NUM_CORE],
   output phold_pkg::core_vec_t         core_ev_ack,
   input  phold_pkg::core_vec_t         core_rdy,
   output phold_pkg::core_vec_t         disp_vld,
   output phold_pkg::lp_id_t            disp_lp,
   output phold_pkg::sim_time_t         disp_ts
);

   phold_pkg::sched_state_e state;
   logic                    init_en;
   logic                    init_done;
   logic                    run;
   phold_pkg::core_vec_t    rx_vld;

   event_if ev_in ();
   event_if ev_out ();

   assign init_en = (state == phold_pkg::INIT);
   assign run     = (state == phold_pkg::RUNNING);

   // core offers are ignored outside RUNNING
   assign rx_vld = run ? core_ev_vld : '0;

   // no restart, DONE holds until reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= phold_pkg::IDLE;
         rtn_vld <= 1'b0;
      end else begin
         rtn_vld <= run && (gvt > sim_end);
         case (state)
            phold_pkg::IDLE: state <= phold_pkg::INIT;
            phold_pkg::INIT: begin
               if (init_done) begin
                  state <= phold_pkg::RUNNING;
               end
            end
            phold_pkg::RUNNING: begin
               if (gvt > sim_end) begin
                  state <= phold_pkg::DONE;
               end
            end
            default: state <= phold_pkg::DONE;
         endcase
      end
   end

   event_collector u_event_collector (
      .clk             (clk),
      .rst_n           (rst_n),
      .init_en         (init_en),
      .num_init_events (num_init_events),
      .init_done       (init_done),
      .core_ev_vld     (rx_vld),
      .core_ev_null    (core_ev_null),
      .core_ev_lp      (core_ev_lp),
      .core_ev_ts      (core_ev_ts),
      .core_ev_ack     (core_ev_ack),
      .ev_in           (ev_in.src)
   );

   event_queue u_event_queue (
      .clk    (clk),
      .rst_n  (rst_n),
      .ev_in  (ev_in.dst),
      .ev_out (ev_out.src)
   );

   // an ack ends the core's current job
   dispatch_unit u_dispatch_unit (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .core_rdy  (core_rdy),
      .core_done (core_ev_ack),
      .ev_out    (ev_out.dst),
      .disp_vld  (disp_vld),
      .disp_lp   (disp_lp),
      .disp_ts   (disp_ts),
      .gvt       (gvt)
   );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`default_nettype none

module clk_gen (
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   // 40 ns period
   localparam int HALF_NS = 20;

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

endmodule

`default_nettype wire

// ==== bench/phold_sched_checker.sv ====
`default_nettype none

module phold_sched_checker (
   input  logic                  clk,
   input  logic                  rst_n,
   input  phold_pkg::sim_time_t  gvt,
   input  logic                  rtn_vld,
   input  phold_pkg::core_vec_t  core_ev_vld,
   input  phold_pkg::core_vec_t  core_ev_ack,
   input  phold_pkg::core_vec_t  core_rdy,
   input  phold_pkg::core_vec_t  disp_vld
);

   timeunit 1ns;
   timeprecision 100ps;

   // number of assertion failures so far
   int fail_cnt = 0;

   // one core per dispatch, and only an idle one
   a_disp_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(disp_vld))
      else begin
         $error("disp_vld has more than one core selected");
         fail_cnt++;
      end

   a_disp_rdy: assert property (@(posedge clk) disable iff (!rst_n)
      (disp_vld & ~core_rdy) == '0)
      else begin
         $error("disp_vld sent to a core without core_rdy");
         fail_cnt++;
      end

   // acks only for cores that offer
   a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(core_ev_ack))
      else begin
         $error("core_ev_ack has more than one core selected");
         fail_cnt++;
      end

   a_ack_vld: assert property (@(posedge clk) disable iff (!rst_n)
      (core_ev_ack & ~core_ev_vld) == '0)
      else begin
         $error("core_ev_ack sent to a core without core_ev_vld");
         fail_cnt++;
      end

   a_rtn_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      rtn_vld |=> !rtn_vld)
      else begin
         $error("rtn_vld held for two cycles");
         fail_cnt++;
      end

   a_gvt_mono: assert property (@(posedge clk) disable iff (!rst_n)
      gvt >= $past(gvt))
      else begin
         $error("gvt went backwards");
         fail_cnt++;
      end

endmodule

`default_nettype wire

// ==== bench/phold_sched_tb.sv ====
`default_nettype none

module phold_sched_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int SEED = 32'h6984;
   localparam int MAX_DELAY = 8;
   localparam int NUM_RUNS = 4;
   localparam int SIM_END = 60;
   localparam int CLK_NS = 40;
   localparam longint TIMEOUT_NS = longint'(CLK_NS) * 10 * (SIM_END + 10) *
                                   phold_pkg::NUM_LP * NUM_RUNS;
   localparam int NO_EVENT = 32'h7fff_ffff;

   // core model states
   localparam int C_IDLE = 0;
   localparam int C_WAIT = 1;
   localparam int C_OFFER = 2;

   logic                           clk;
   logic                           rst_n;
   phold_pkg::sim_time_t           sim_end;
   logic [phold_pkg::NB_LPID:0]    num_init;
   phold_pkg::sim_time_t           gvt;
   logic                           rtn_vld;
   phold_pkg::core_vec_t           core_ev_vld = '0;
   phold_pkg::core_vec_t           core_ev_null = '0;
   phold_pkg::lp_id_t              core_ev_lp [phold_pkg::NUM_CORE] = '{default: '0};
   phold_pkg::sim_time_t           core_ev_ts [phold_pkg::NUM_CORE] = '{default: '0};
   phold_pkg::core_vec_t           core_ev_ack;
   phold_pkg::core_vec_t           core_rdy = '1;
   phold_pkg::core_vec_t           disp_vld;
   phold_pkg::lp_id_t              disp_lp;
   phold_pkg::sim_time_t           disp_ts;

   // reference model, events waiting in the queue
   phold_pkg::lp_id_t              mset_lp [$];
   phold_pkg::sim_time_t           mset_ts [$];
   int                             core_state [phold_pkg::NUM_CORE];
   int                             delay_cnt [phold_pkg::NUM_CORE];
   phold_pkg::sim_time_t           job_ts [phold_pkg::NUM_CORE];
   logic                           offer_null [phold_pkg::NUM_CORE];
   logic [phold_pkg::NUM_LP-1:0]   init_seen;
   int                             init_cnt;
   int                             init_total;

   clk_gen u_clk_gen (
      .clk (clk)
   );

   phold_sched u_phold_sched (
      .clk             (clk),
      .rst_n           (rst_n),
      .sim_end         (sim_end),
      .num_init_events (num_init),
      .gvt             (gvt),
      .rtn_vld         (rtn_vld),
      .core_ev_vld     (core_ev_vld),
      .core_ev_null    (core_ev_null),
      .core_ev_lp      (core_ev_lp),
      .core_ev_ts      (core_ev_ts),
      .core_ev_ack     (core_ev_ack),
      .core_rdy        (core_rdy),
      .disp_vld        (disp_vld),
      .disp_lp         (disp_lp),
      .disp_ts         (disp_ts)
   );

   bind phold_sched phold_sched_checker u_phold_sched_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .gvt         (gvt),
      .rtn_vld     (rtn_vld),
      .core_ev_vld (core_ev_vld),
      .core_ev_ack (core_ev_ack),
      .core_rdy    (core_rdy),
      .disp_vld    (disp_vld)
   );

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   function automatic int mset_min();
      int m;
      m = NO_EVENT;
      foreach (mset_ts[j]) begin
         if (int'(mset_ts[j]) < m) begin
            m = int'(mset_ts[j]);
         end
      end
      return m;
   endfunction

   // queued events plus jobs still held by cores
   function automatic int live_min();
      int m;
      m = mset_min();
      for (int i = 0; i < phold_pkg::NUM_CORE; i++) begin
         if (core_state[i] != C_IDLE && int'(job_ts[i]) < m) begin
            m = int'(job_ts[i]);
         end
      end
      return m;
   endfunction

   function automatic int find_event(input phold_pkg::lp_id_t lp, input phold_pkg::sim_time_t ts);
      foreach (mset_ts[j]) begin
         if (mset_ts[j] == ts && mset_lp[j] == lp) begin
            return j;
         end
      end
      return -1;
   endfunction

   // the DUT makes LPs 0 to n-1 at time 0
   task automatic load_model();
      mset_lp.delete();
      mset_ts.delete();
      for (int k = 0; k < init_total; k++) begin
         mset_lp.push_back(phold_pkg::lp_id_t'(k));
         mset_ts.push_back('0);
      end
      init_seen = '0;
      init_cnt = 0;
   endtask

   // core models and reference model, one step per clock
   always @(posedge clk) begin : model_step
      int lm;
      int live;
      int idx;
      int k;
      if (!rst_n) begin
         for (int i = 0; i < phold_pkg::NUM_CORE; i++) begin
            core_state[i] = C_IDLE;
            offer_null[i] = 1'b0;
         end
         core_rdy <= '1;
         core_ev_vld <= '0;
         core_ev_null <= '0;
      end else begin
         if (u_phold_sched.u_phold_sched_checker.fail_cnt != 0) begin
            report_failure("a bound assertion on the DUT ports failed");
         end
         lm = live_min();
         if (lm != NO_EVENT && int'(gvt) > lm) begin
            report_failure($sformatf("[ERROR] gvt: 0x%h above earliest live time 0x%h", gvt, lm));
         end
         for (int i = 0; i < phold_pkg::NUM_CORE; i++) begin
            if (core_ev_ack[i]) begin
               if (core_state[i] != C_OFFER) begin
                  report_failure($sformatf("core %0d was acknowledged without an offer", i));
               end
               if (!core_ev_null[i]) begin
                  mset_lp.push_back(core_ev_lp[i]);
                  mset_ts.push_back(core_ev_ts[i]);
               end
               core_state[i] = C_IDLE;
               core_ev_vld[i] <= 1'b0;
               core_rdy[i] <= 1'b1;
            end
         end
         live = mset_ts.size();
         for (int i = 0; i < phold_pkg::NUM_CORE; i++) begin
            if (core_state[i] == C_WAIT || (core_state[i] == C_OFFER && !offer_null[i])) begin
               live++;
            end
         end
         // the last live event never retires as null, so GVT can advance
         for (int i = 0; i < phold_pkg::NUM_CORE; i++) begin
            if (core_state[i] == C_WAIT) begin
               if (delay_cnt[i] == 0) begin
                  offer_null[i] = (live > 1) && (($urandom % 8) == 0);
                  if (offer_null[i]) begin
                     live--;
                  end
                  core_ev_vld[i] <= 1'b1;
                  core_ev_null[i] <= offer_null[i];
                  core_ev_lp[i] <= phold_pkg::lp_id_t'($urandom % phold_pkg::NUM_LP);
                  core_ev_ts[i] <= job_ts[i] + phold_pkg::sim_time_t'(1 + $urandom % MAX_DELAY);
                  core_state[i] = C_OFFER;
               end else begin
                  delay_cnt[i]--;
               end
            end
         end
         if (disp_vld != '0) begin
            idx = 0;
            for (int i = 0; i < phold_pkg::NUM_CORE; i++) begin
               if (disp_vld[i]) begin
                  idx = i;
               end
            end
            if (disp_ts < gvt) begin
               report_failure($sformatf("[ERROR] disp_ts: 0x%h below gvt 0x%h", disp_ts, gvt));
            end
            compare("disp_ts", 32'(disp_ts), mset_min());
            k = find_event(disp_lp, disp_ts);
            if (k < 0) begin
               report_failure($sformatf("dispatched event for LP %0d at time %0d was never queued",
                                        disp_lp, disp_ts));
            end
            mset_lp.delete(k);
            mset_ts.delete(k);
            if (disp_ts == '0) begin
               if (int'(disp_lp) >= init_total || init_seen[disp_lp]) begin
                  report_failure($sformatf("[ERROR] disp_lp: 0x%h is not a new initial event",
                                           disp_lp));
               end
               init_seen[disp_lp] = 1'b1;
               init_cnt++;
            end
            core_state[idx] = C_WAIT;
            delay_cnt[idx] = $urandom % MAX_DELAY;
            job_ts[idx] = disp_ts;
            core_rdy[idx] <= 1'b0;
         end
      end
   end

   initial begin : stimulus
      void'($urandom(SEED));
      rst_n <= 1'b0;
      sim_end <= phold_pkg::sim_time_t'(SIM_END);
      num_init <= '0;
      init_total = 0;
      for (int r = 0; r < NUM_RUNS; r++) begin
         @(posedge clk);
         // first run fills the queue
         if (r == 0) begin
            init_total = phold_pkg::NUM_LP;
         end else begin
            init_total = 1 + ($urandom % phold_pkg::NUM_LP);
         end
         rst_n <= 1'b0;
         num_init <= (phold_pkg::NB_LPID + 1)'(init_total);
         repeat (10) @(posedge clk);
         load_model();
         rst_n <= 1'b1;
         do begin
            @(posedge clk);
         end while (rtn_vld !== 1'b1);
         if (gvt <= sim_end) begin
            report_failure($sformatf("[ERROR] gvt: 0x%h not past sim_end 0x%h at rtn_vld",
                                     gvt, sim_end));
         end
         // DONE stays quiet
         repeat (50) begin
            @(posedge clk);
            compare("disp_vld", 32'(disp_vld), 32'h0);
            compare("core_ev_ack", 32'(core_ev_ack), 32'h0);
            compare("rtn_vld", 32'(rtn_vld), 32'h0);
         end
         compare("init_dispatches", init_cnt, init_total);
      end
      if (u_phold_sched.u_phold_sched_checker.fail_cnt == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         report_failure("a bound assertion on the DUT ports failed");
      end
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      report_failure("watchdog expired before the last run reached its end of simulation");
   end

endmodule

`default_nettype wire

// ==== phold_sched.f ====
design/phold_pkg.sv
design/event_if.sv
design/rr_arbiter.sv
design/event_collector.sv
design/event_queue.sv
design/dispatch_unit.sv
design/phold_sched.sv
bench/clk_gen.sv
bench/phold_sched_checker.sv
bench/phold_sched_tb.sv

// ==== Bender.yml ====
package:
  name: phold_sched

sources:
  - files:
      - design/phold_pkg.sv
      - design/event_if.sv
      - design/rr_arbiter.sv
      - design/event_collector.sv
      - design/event_queue.sv
      - design/dispatch_unit.sv
      - design/phold_sched.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/phold_sched_checker.sv
      - bench/phold_sched_tb.sv
